//--- bench/gainCoeffBench.sv
module gainCoeffBench;

	timeunit 1ns;
	timeprecision 1ps;

	import g729DataPkg::*;
	import g729CtrlPkg::*;

	`include "g729Gain_config.svh"

	localparam int DONE_TIMEOUT = 20;
	localparam int BUSY_TIMEOUT = 4;
	localparam int DONE_CYCLE = 8;

	logic clock;
	logic reset;
	logic start;
	gainCommand_t command;
	memWrite_t hostWrite;
	scratchAddr_t hostReadAddr;
	word32_t hostReadData;
	logic busy;
	logic done;

	// reference copy of the scratch RAM
	word32_t model [`G729_MEM_DEPTH];
	logic [31:0] rngState;
	int errorCount;
	int timeoutCount;
	int checkCount;

	gainCoeffTop UUT
	(
		.clock(clock), .reset(reset), .start(start), .command(command),
		.hostWrite(hostWrite), .hostReadAddr(hostReadAddr),
		.hostReadData(hostReadData), .busy(busy), .done(done)
	);

	// 20 ns period
	always #10 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// random source and reference arithmetic
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// clamp the true sum into 16 bits
	function automatic word16_t saturatingAdd16(input word16_t a, input word16_t b);
		int sum;
		sum = int'($signed(a)) + int'($signed(b));
		if (sum > 32767)
			sum = 32767;
		else if (sum < -32768)
			sum = -32768;
		return word16_t'(sum);
	endfunction

	// true negation, then clip to the 32-bit range
	function automatic word32_t longNegate(input word32_t x);
		longint value;
		value = -longint'($signed(x));
		if (value > 64'sd2147483647)
			value = 64'sd2147483647;
		return word32_t'(value);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// host port access
	////////////////////////////////////////////////////////////////////////////

	task automatic writeHost(input scratchAddr_t addr, input word32_t data);
		@(posedge clock);
		hostWrite <= {addr, data, 1'b1};
		model[addr] = data;
	endtask

	task automatic readCompare(input scratchAddr_t addr, input word32_t expected,
		input string what);
		@(posedge clock);
		hostWrite.en <= 1'b0;
		hostReadAddr <= addr;
		@(posedge clock);
		@(negedge clock);
		checkCount++;
		if (hostReadData !== expected)
		begin
			errorCount++;
			$display("ERROR hostReadData addr %h (%s) expected %h got %h",
				addr, what, expected, hostReadData);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// commands
	////////////////////////////////////////////////////////////////////////////

	// the four sources and four targets never overlap
	task automatic pickCommand(output gainCommand_t cmd);
		scratchAddr_t swap;
		cmd.coeffBase = scratchAddr_t'(nextRandom());
		cmd.copyBase = cmd.coeffBase + scratchAddr_t'(4 + nextRandom() % 1000);
		cmd.expBase = cmd.copyBase + scratchAddr_t'(2 + nextRandom() % 1000);
		if (nextRandom() & 32'h1)
		begin
			swap = cmd.copyBase;
			cmd.copyBase = cmd.expBase;
			cmd.expBase = swap;
		end
	endtask

	task automatic loadSources(input gainCommand_t cmd);
		for (int i = 0; i < 4; i++)
			writeHost(cmd.coeffBase + scratchAddr_t'(i), nextRandom());
	endtask

	// the four updates in encoder order
	task automatic applyModel(input gainCommand_t cmd);
		word32_t srcLast;
		word16_t sum;
		model[cmd.copyBase] = model[cmd.coeffBase];
		model[cmd.expBase] = longNegate(model[cmd.coeffBase + 12'd1]);
		model[cmd.copyBase + 12'd1] = longNegate(model[cmd.coeffBase + 12'd2]);
		srcLast = model[cmd.coeffBase + 12'd3];
		sum = saturatingAdd16(srcLast[15:0], 16'h0001);
		model[cmd.expBase + 12'd1] = longNegate({{16{sum[15]}}, sum});
	endtask

	task automatic checkRun(input gainCommand_t cmd);
		readCompare(cmd.copyBase, model[cmd.copyBase], "g_coeff_cs[0]");
		readCompare(cmd.copyBase + 12'd1, model[cmd.copyBase + 12'd1], "g_coeff_cs[1]");
		readCompare(cmd.expBase, model[cmd.expBase], "exp_g_coeff_cs[0]");
		readCompare(cmd.expBase + 12'd1, model[cmd.expBase + 12'd1], "exp_g_coeff_cs[1]");
		for (int i = 0; i < 4; i++)
			readCompare(cmd.coeffBase + scratchAddr_t'(i),
				model[cmd.coeffBase + scratchAddr_t'(i)], "g_coeff");
	endtask

	// start a run and watch busy and done each cycle
	// disturb pokes a second start and a host write in while busy
	task automatic runCommand(input gainCommand_t cmd, input bit disturb,
		input gainCommand_t other, input scratchAddr_t dropAddr);
		int cycle;
		int waited;
		bit seen;
		cycle = 0;
		seen = 1'b0;
		@(posedge clock);
		start <= 1'b1;
		command <= cmd;
		hostWrite.en <= 1'b0;
		// start edge
		@(posedge clock);
		start <= 1'b0;
		while (!seen && cycle < DONE_TIMEOUT)
		begin
			@(negedge clock);
			cycle++;
			if (busy !== 1'b1)
			begin
				errorCount++;
				$display("ERROR busy cycle %0d expected 1 got %h", cycle, busy);
			end
			if (done === 1'b1)
			begin
				seen = 1'b1;
				if (cycle != DONE_CYCLE)
				begin
					errorCount++;
					$display("ERROR done cycle expected %h got %h", DONE_CYCLE, cycle);
				end
			end
			if (disturb && cycle == 2)
			begin
				@(posedge clock);
				start <= 1'b1;
				command <= other;
				hostWrite <= {dropAddr, nextRandom(), 1'b1};
			end
			if (disturb && cycle == 3)
			begin
				@(posedge clock);
				start <= 1'b0;
				hostWrite.en <= 1'b0;
			end
		end
		if (!seen)
		begin
			timeoutCount++;
			$display("done did not arrive within %0d cycles of start", DONE_TIMEOUT);
			return;
		end
		waited = 0;
		while (busy === 1'b1 && waited < BUSY_TIMEOUT)
		begin
			@(negedge clock);
			waited++;
		end
		if (busy !== 1'b0)
		begin
			timeoutCount++;
			$display("busy stayed high %0d cycles after done", BUSY_TIMEOUT);
			return;
		end
		if (waited != 1)
		begin
			errorCount++;
			$display("ERROR busy fall cycle expected %h got %h", 1, waited);
		end
		if (done !== 1'b0)
		begin
			errorCount++;
			$display("ERROR done after run expected 0 got %h", done);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	task automatic runAllTests();
		gainCommand_t cmd;
		gainCommand_t other;
		@(negedge clock);
		if (busy !== 1'b0)
		begin
			errorCount++;
			$display("ERROR busy after reset expected 0 got %h", busy);
		end
		if (done !== 1'b0)
		begin
			errorCount++;
			$display("ERROR done after reset expected 0 got %h", done);
		end
		// whole RAM from the random stream, then spot reads
		for (int i = 0; i < `G729_MEM_DEPTH; i++)
			writeHost(scratchAddr_t'(i), nextRandom());
		for (int i = 0; i < 16; i++)
		begin
			cmd.coeffBase = scratchAddr_t'(nextRandom());
			readCompare(cmd.coeffBase, model[cmd.coeffBase], "fill");
		end
		for (int i = 0; i < 40; i++)
		begin
			pickCommand(cmd);
			loadSources(cmd);
			runCommand(cmd, 1'b0, cmd, cmd.coeffBase);
			if (timeoutCount != 0)
				return;
			applyModel(cmd);
			checkRun(cmd);
		end
		// most negative long and a saturating short
		pickCommand(cmd);
		writeHost(cmd.coeffBase, nextRandom());
		writeHost(cmd.coeffBase + 12'd1, 32'h80000000);
		writeHost(cmd.coeffBase + 12'd2, 32'h80000000);
		writeHost(cmd.coeffBase + 12'd3, {word16_t'(nextRandom() >> 16), 16'h7fff});
		runCommand(cmd, 1'b0, cmd, cmd.coeffBase);
		if (timeoutCount != 0)
			return;
		applyModel(cmd);
		checkRun(cmd);
		readCompare(cmd.expBase, 32'h7fffffff, "negated min");
		readCompare(cmd.copyBase + 12'd1, 32'h7fffffff, "negated min");
		readCompare(cmd.expBase + 12'd1, 32'hffff8001, "saturated sum");
		// minus one plus one
		pickCommand(cmd);
		loadSources(cmd);
		writeHost(cmd.coeffBase + 12'd3, {word16_t'(nextRandom() >> 16), 16'hffff});
		runCommand(cmd, 1'b0, cmd, cmd.coeffBase);
		if (timeoutCount != 0)
			return;
		applyModel(cmd);
		checkRun(cmd);
		readCompare(cmd.expBase + 12'd1, 32'h00000000, "zero sum");
		// second start and host write while busy are both dropped
		pickCommand(cmd);
		loadSources(cmd);
		other.coeffBase = cmd.coeffBase + 12'd2010;
		other.copyBase = cmd.coeffBase + 12'd2014;
		other.expBase = cmd.coeffBase + 12'd2016;
		runCommand(cmd, 1'b1, other, cmd.coeffBase);
		if (timeoutCount != 0)
			return;
		applyModel(cmd);
		checkRun(cmd);
		readCompare(other.copyBase, model[other.copyBase], "dropped copy");
		readCompare(other.copyBase + 12'd1, model[other.copyBase + 12'd1], "dropped copy");
		readCompare(other.expBase, model[other.expBase], "dropped exp");
		readCompare(other.expBase + 12'd1, model[other.expBase + 12'd1], "dropped exp");
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		command = '0;
		hostWrite = '0;
		hostReadAddr = '0;
		rngState = 32'h7c72;
		errorCount = 0;
		timeoutCount = 0;
		checkCount = 0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		runAllTests();
		$display("word checks %0d, value errors %0d, timeouts %0d",
			checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- g729Gain.f
+incdir+src
src/g729DataPkg.sv
src/g729CtrlPkg.sv
src/gainCommandLatch.sv
src/g729BasicOps.sv
src/gainCoeffSequencer.sv
src/scratchMemory.sv
src/gainCoeffTop.sv
bench/gainCoeffBench.sv

//--- src/g729BasicOps.sv
module g729BasicOps
(
	input g729DataPkg::word16_t addA,
	input g729DataPkg::word16_t addB,
	output g729DataPkg::word16_t addSum,
	input g729DataPkg::word32_t negIn,
	output g729DataPkg::word32_t negOut
);

	import g729DataPkg::*;

	// extreme values of the basic-op formats
	localparam word16_t MAX16 = 16'h7fff;
	localparam word16_t MIN16 = 16'h8000;
	localparam word32_t MAX32 = 32'h7fffffff;
	localparam word32_t MIN32 = 32'h80000000;

	// one extra bit to see overflow
	logic [16:0] wideSum;
	logic overflow;

	////////////////////////////////////////////////////////////////////////////
	// add with saturation
	////////////////////////////////////////////////////////////////////////////

	// sign extend both operands
	assign wideSum = {addA[15], addA} + {addB[15], addB};

	// top two bits disagree on signed overflow
	assign overflow = wideSum[16] ^ wideSum[15];

	always_comb
	begin
		if (!overflow)
			addSum = wideSum[15:0];
		else if (wideSum[16])
			// negative overflow
			addSum = MIN16;
		else
			addSum = MAX16;
	end

	////////////////////////////////////////////////////////////////////////////
	// long negate
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// most negative has no positive twin
		if (negIn == MIN32)
			negOut = MAX32;
		else
			negOut = ~negIn + word32_t'(1);
	end

endmodule

//--- src/g729CtrlPkg.sv
package g729CtrlPkg;

	////////////////////////////////////////////////////////////////////////////
	// command from the top level FSM
	////////////////////////////////////////////////////////////////////////////

	// base of g_coeff, g_coeff_cs and exp_g_coeff_cs
	typedef struct packed
	{
		g729DataPkg::scratchAddr_t coeffBase;
		g729DataPkg::scratchAddr_t copyBase;
		g729DataPkg::scratchAddr_t expBase;
	} gainCommand_t;

	////////////////////////////////////////////////////////////////////////////
	// sequencer states
	////////////////////////////////////////////////////////////////////////////

	// one state per clock after leaving IDLE
	typedef enum logic [2:0]
	{
		IDLE,
		COPY,
		NEG_FIRST,
		NEG_SECOND,
		ADDR_EXP,
		FETCH_LAST,
		NEG_SUM,
		FINISH
	} seqState_t;

endpackage

//--- src/g729DataPkg.sv
package g729DataPkg;

	`include "g729Gain_config.svh"

	////////////////////////////////////////////////////////////////////////////
	// data words and addresses
	////////////////////////////////////////////////////////////////////////////

	// word index into scratch memory
	typedef logic [`G729_ADDR_WIDTH-1:0] scratchAddr_t;

	// Q-format short value
	typedef logic [15:0] word16_t;

	// long value as held in memory
	typedef logic [`G729_DATA_WIDTH-1:0] word32_t;

	////////////////////////////////////////////////////////////////////////////
	// memory write request
	////////////////////////////////////////////////////////////////////////////

	// en qualifies the whole request
	typedef struct packed
	{
		scratchAddr_t addr;
		word32_t data;
		logic en;
	} memWrite_t;

endpackage

//--- src/g729Gain_config.svh
`ifndef G729_GAIN_CONFIG_SVH
`define G729_GAIN_CONFIG_SVH

// scratch memory geometry shared by the encoder blocks

// word address into the scratch RAM
`define G729_ADDR_WIDTH 12

// one long word as stored in scratch
`define G729_DATA_WIDTH 32

// full 12-bit address space
`define G729_MEM_DEPTH 4096

`endif

//--- src/gainCoeffSequencer.sv
module gainCoeffSequencer
(
	input logic clock,
	input logic reset,
	input logic cmdValid,
	input g729CtrlPkg::gainCommand_t cmdReg,
	output g729DataPkg::word16_t addA,
	output g729DataPkg::word16_t addB,
	input g729DataPkg::word16_t addSum,
	output g729DataPkg::word32_t negIn,
	input g729DataPkg::word32_t negOut,
	output g729DataPkg::scratchAddr_t seqReadAddr,
	input g729DataPkg::word32_t seqReadData,
	output g729DataPkg::memWrite_t seqWrite,
	output logic done,
	output logic finished
);

	import g729DataPkg::*;
	import g729CtrlPkg::*;

	seqState_t state;
	seqState_t nextState;

	// exp_g_coeff_cs[1] kept across the fetch
	scratchAddr_t expHold;

	// neighbour addresses of the bases
	scratchAddr_t coeffPlus1;
	scratchAddr_t coeffPlus2;
	scratchAddr_t coeffPlus3;
	scratchAddr_t copyPlus1;
	scratchAddr_t expPlus1;

	// plain increments that wrap at the top of scratch
	assign coeffPlus1 = cmdReg.coeffBase + scratchAddr_t'(1);
	assign coeffPlus2 = cmdReg.coeffBase + scratchAddr_t'(2);
	assign coeffPlus3 = cmdReg.coeffBase + scratchAddr_t'(3);
	assign copyPlus1 = cmdReg.copyBase + scratchAddr_t'(1);
	assign expPlus1 = cmdReg.expBase + scratchAddr_t'(1);

	////////////////////////////////////////////////////////////////////////////
	// state register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= nextState;
	end

	// E+1 latched on the way through ADDR_EXP
	always_ff @(posedge clock)
	begin
		if (state == ADDR_EXP)
			expHold <= expPlus1;
	end

	////////////////////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		case (state)
			IDLE:
				if (cmdValid)
					nextState = COPY;
			COPY: nextState = NEG_FIRST;
			NEG_FIRST: nextState = NEG_SECOND;
			NEG_SECOND: nextState = ADDR_EXP;
			ADDR_EXP: nextState = FETCH_LAST;
			FETCH_LAST: nextState = NEG_SUM;
			NEG_SUM: nextState = FINISH;
			FINISH: nextState = IDLE;
			default: nextState = IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// datapath control
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		addA = '0;
		addB = '0;
		negIn = '0;
		seqReadAddr = '0;
		seqWrite = '0;
		case (state)
			// g_coeff[0] fetched while waiting
			IDLE:
				seqReadAddr = cmdReg.coeffBase;
			// g_coeff_cs[0] = g_coeff[0]
			COPY:
			begin
				seqWrite.addr = cmdReg.copyBase;
				seqWrite.data = seqReadData;
				seqWrite.en = 1'b1;
				seqReadAddr = coeffPlus1;
			end
			// exp_g_coeff_cs[0] = negate(g_coeff[1])
			NEG_FIRST:
			begin
				negIn = seqReadData;
				seqWrite.addr = cmdReg.expBase;
				seqWrite.data = negOut;
				seqWrite.en = 1'b1;
				seqReadAddr = coeffPlus2;
			end
			// g_coeff_cs[1] = negate(g_coeff[2])
			NEG_SECOND:
			begin
				negIn = seqReadData;
				seqWrite.addr = copyPlus1;
				seqWrite.data = negOut;
				seqWrite.en = 1'b1;
			end
			// g_coeff[3] fetched
			FETCH_LAST:
				seqReadAddr = coeffPlus3;
			// exp_g_coeff_cs[1] = negate(add(g_coeff[3], 1))
			NEG_SUM:
			begin
				addA = seqReadData[15:0];
				addB = word16_t'(1);
				negIn = {{16{addSum[15]}}, addSum};
				seqWrite.addr = expHold;
				seqWrite.data = negOut;
				seqWrite.en = 1'b1;
			end
			default:
			begin
				// ADDR_EXP and FINISH drive nothing here
			end
		endcase
	end

	// handshake back to the latch and the caller
	assign done = (state == FINISH);
	assign finished = (state == FINISH);

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// a command in the middle of a run would be lost
	cmdWhileIdle: assert property (@(posedge clock) disable iff (reset)
		cmdValid |-> state == IDLE)
		else $error("cmdValid arrived while the sequencer was still running");

endmodule

//--- src/gainCoeffTop.sv
module gainCoeffTop
(
	input logic clock,
	input logic reset,
	input logic start,
	input g729CtrlPkg::gainCommand_t command,
	input g729DataPkg::memWrite_t hostWrite,
	input g729DataPkg::scratchAddr_t hostReadAddr,
	output g729DataPkg::word32_t hostReadData,
	output logic busy,
	output logic done
);

	import g729DataPkg::*;
	import g729CtrlPkg::*;

	// latch to sequencer
	logic cmdValid;
	logic finished;
	gainCommand_t cmdReg;

	// sequencer to basic ops
	word16_t addA;
	word16_t addB;
	word16_t addSum;
	word32_t negIn;
	word32_t negOut;

	// sequencer to scratch memory
	scratchAddr_t seqReadAddr;
	word32_t seqReadData;
	memWrite_t seqWrite;

	////////////////////////////////////////////////////////////////////////////
	// blocks
	////////////////////////////////////////////////////////////////////////////

	gainCommandLatch cmdLatch
	(
		.clock(clock), .reset(reset), .start(start), .finished(finished),
		.command(command), .cmdValid(cmdValid), .busy(busy), .cmdReg(cmdReg)
	);

	g729BasicOps basicOps
	(
		.addA(addA), .addB(addB), .addSum(addSum), .negIn(negIn), .negOut(negOut)
	);

	gainCoeffSequencer sequencer
	(
		.clock(clock), .reset(reset), .cmdValid(cmdValid), .cmdReg(cmdReg),
		.addA(addA), .addB(addB), .addSum(addSum), .negIn(negIn), .negOut(negOut),
		.seqReadAddr(seqReadAddr), .seqReadData(seqReadData), .seqWrite(seqWrite),
		.done(done), .finished(finished)
	);

	scratchMemory scratch
	(
		.clock(clock), .reset(reset), .busy(busy),
		.hostWrite(hostWrite), .seqWrite(seqWrite),
		.hostReadAddr(hostReadAddr), .seqReadAddr(seqReadAddr),
		.hostReadData(hostReadData), .seqReadData(seqReadData)
	);

endmodule

//--- src/gainCommandLatch.sv
module gainCommandLatch
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic finished,
	input g729CtrlPkg::gainCommand_t command,
	output logic cmdValid,
	output logic busy,
	output g729CtrlPkg::gainCommand_t cmdReg
);

	// start only counts while idle
	logic accept;

	assign accept = start && !busy;

	////////////////////////////////////////////////////////////////////////////
	// busy flag and command strobe
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			cmdValid <= 1'b0;
		end
		else
		begin
			// strobe lands one cycle after the start edge
			cmdValid <= accept;
			if (accept)
				busy <= 1'b1;
			else if (finished)
				busy <= 1'b0;
		end
	end

	// base addresses held for the whole run
	always_ff @(posedge clock)
	begin
		if (accept)
			cmdReg <= command;
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// finished only closes a command that has been running a while
	finishWhileBusy: assert property (@(posedge clock) disable iff (reset)
		finished |-> busy && $past(busy))
		else $error("finished arrived without a command in flight");

endmodule

//--- src/scratchMemory.sv
module scratchMemory
(
	input logic clock,
	input logic reset,
	input logic busy,
	input g729DataPkg::memWrite_t hostWrite,
	input g729DataPkg::memWrite_t seqWrite,
	input g729DataPkg::scratchAddr_t hostReadAddr,
	input g729DataPkg::scratchAddr_t seqReadAddr,
	output g729DataPkg::word32_t hostReadData,
	output g729DataPkg::word32_t seqReadData
);

	import g729DataPkg::*;

	`include "g729Gain_config.svh"

	word32_t ram [`G729_MEM_DEPTH];

	// busy picks the owner of the single write port
	memWrite_t portWrite;

	assign portWrite = busy ? seqWrite : hostWrite;

	////////////////////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (portWrite.en)
			ram[portWrite.addr] <= portWrite.data;
	end

	////////////////////////////////////////////////////////////////////////////
	// registered reads
	////////////////////////////////////////////////////////////////////////////

	// old word on a same cycle write
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			hostReadData <= '0;
			seqReadData <= '0;
		end
		else
		begin
			seqReadData <= ram[seqReadAddr];
			// host port frozen during a run
			if (!busy)
				hostReadData <= ram[hostReadAddr];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// sequencer writes only reach the RAM while busy
	seqWriteWhileBusy: assert property (@(posedge clock) disable iff (reset)
		seqWrite.en |-> busy)
		else $error("sequencer write while idle was dropped by the port select");

endmodule
